/* verilog/ft_types_pkg.sv */
`default_nettype none

package ft_types_pkg;

    localparam int NUM_WAYS = 4;

    // Odd, so the ways land on different slots.
    localparam int HASH_STRIDE = 5;

    typedef logic [95:0] tuple_t;
    typedef logic [7:0]  queue_id_t;
    typedef logic [15:0] pkt_len_t;
    typedef logic [31:0] hash_t;

    // Queue id of a packet that missed every way.
    localparam queue_id_t DROP_QUEUE = '1;

    typedef struct packed {
        logic      valid;
        tuple_t    tuple;
        queue_id_t queue_id;
    } flow_entry_t;

    typedef struct packed {
        tuple_t    tuple;
        queue_id_t queue_id;
        pkt_len_t  pkt_len;
    } pkt_meta_t;

    // XOR fold into awidth-bit chunks and add a per-way offset.
    function automatic hash_t way_index(tuple_t tuple, int way, int awidth);
        hash_t fold;
        hash_t mask;
        fold = '0;
        mask = (hash_t'(1) << awidth) - hash_t'(1);
        for (int i = 0; i < $bits(tuple_t); i++) begin
            fold[i % awidth] = fold[i % awidth] ^ tuple[i];
        end
        return (fold + hash_t'(way * HASH_STRIDE)) & mask;
    endfunction

endpackage

`default_nettype wire

/* verilog/ft_ctrl_pkg.sv */
`default_nettype none

package ft_ctrl_pkg;

    import ft_types_pkg::*;

    typedef struct packed {
        tuple_t    tuple;
        queue_id_t queue_id;
    } flow_rule_t;

    typedef enum logic [1:0] {
        PLACE_UPDATED,
        PLACE_INSERTED,
        PLACE_TABLE_FULL
    } place_status_t;

    typedef enum logic [2:0] {
        P_IDLE,
        P_READ,
        P_WAIT,
        P_DECIDE,
        P_WRITE,
        P_ACK
    } place_state_t;

endpackage

`default_nettype wire

/* verilog/flow_subtable.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_subtable import ft_types_pkg::*; #(
    parameter int AWIDTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [AWIDTH-1:0] a_addr,
    input  logic              a_en,
    output flow_entry_t       a_entry,
    input  logic [AWIDTH-1:0] b_addr,
    input  logic              b_rd,
    input  logic              b_wr,
    input  flow_entry_t       b_data,
    output flow_entry_t       b_entry
);

    localparam int DEPTH = 1 << AWIDTH;

    tuple_t           tuple_mem [DEPTH];
    queue_id_t        queue_mem [DEPTH];
    logic [DEPTH-1:0] valid_q;

    // Reset empties every slot of the way.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (b_wr) begin
            valid_q[b_addr] <= b_data.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (b_wr) begin
            tuple_mem[b_addr] <= b_data.tuple;
            queue_mem[b_addr] <= b_data.queue_id;
        end
    end

    // Lookup port, read only.
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_entry.valid    <= valid_q[a_addr];
            a_entry.tuple    <= tuple_mem[a_addr];
            a_entry.queue_id <= queue_mem[a_addr];
        end
    end

    // Placement port.
    always_ff @(posedge clk) begin
        if (b_rd) begin
            b_entry.valid    <= valid_q[b_addr];
            b_entry.tuple    <= tuple_mem[b_addr];
            b_entry.queue_id <= queue_mem[b_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/flow_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_lookup import ft_types_pkg::*; #(
    parameter int AWIDTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  pkt_meta_t         in_meta,
    input  logic              in_valid,
    output logic              in_ready,
    output pkt_meta_t         out_meta,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [AWIDTH-1:0] rd_addr [NUM_WAYS],
    output logic              rd_en,
    input  flow_entry_t       rd_entry [NUM_WAYS]
);

    pkt_meta_t           s1_meta;
    logic                s1_valid;
    pkt_meta_t           s2_meta;
    logic                s2_valid;
    hash_t               way_hash [NUM_WAYS];
    logic [NUM_WAYS-1:0] hit;
    queue_id_t           hit_queue;

    // Downstream back-pressure freezes every stage.
    assign in_ready = out_ready;

    // Memory read is issued from stage 1 and lands beside stage 2.
    assign rd_en = s1_valid && out_ready;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        assign way_hash[w] = way_index(s1_meta.tuple, w, AWIDTH);
        assign rd_addr[w]  = way_hash[w][AWIDTH-1:0];
        assign hit[w]      = rd_entry[w].valid && (rd_entry[w].tuple == s2_meta.tuple);
    end

    // Lowest matching way wins.
    always_comb begin
        hit_queue = DROP_QUEUE;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit[w]) begin
                hit_queue = rd_entry[w].queue_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (out_ready) begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (out_ready) begin
            s1_meta <= in_meta;
            s2_meta <= s1_meta;
            if (s2_valid) begin
                out_meta <= '{
                    tuple:    s2_meta.tuple,
                    queue_id: hit_queue,
                    pkt_len:  s2_meta.pkt_len
                };
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/flow_placer.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_placer import ft_types_pkg::*, ft_ctrl_pkg::*; #(
    parameter int AWIDTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ctrl_req,
    input  flow_rule_t          ctrl_rule,
    output logic                ctrl_ack,
    output place_status_t       ctrl_status,
    output logic [31:0]         eviction_cnt,
    output logic [AWIDTH-1:0]   wr_addr [NUM_WAYS],
    output logic [NUM_WAYS-1:0] wr_rd,
    output logic [NUM_WAYS-1:0] wr_en,
    output flow_entry_t         wr_data,
    input  flow_entry_t         wr_entry [NUM_WAYS]
);

    place_state_t        state;
    flow_rule_t          rule_q;
    hash_t               way_hash [NUM_WAYS];
    logic [NUM_WAYS-1:0] hit;
    logic [NUM_WAYS-1:0] empty;
    logic [NUM_WAYS-1:0] hit_q;
    logic [NUM_WAYS-1:0] empty_q;
    logic [NUM_WAYS-1:0] sel_q;
    place_status_t       status_q;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        assign way_hash[w] = way_index(rule_q.tuple, w, AWIDTH);
        assign wr_addr[w]  = way_hash[w][AWIDTH-1:0];
        assign hit[w]      = wr_entry[w].valid && (wr_entry[w].tuple == rule_q.tuple);
        assign empty[w]    = !wr_entry[w].valid;
    end

    assign ctrl_ack    = (state == P_ACK);
    assign ctrl_status = status_q;
    assign wr_rd       = {NUM_WAYS{state == P_READ}};
    assign wr_en       = (state == P_WRITE) ? sel_q : '0;
    assign wr_data     = '{valid: 1'b1, tuple: rule_q.tuple, queue_id: rule_q.queue_id};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= P_IDLE;
            eviction_cnt <= '0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (ctrl_req) begin
                        state <= P_READ;
                    end
                end
                P_READ: state <= P_WAIT;
                P_WAIT: state <= P_DECIDE;
                P_DECIDE: state <= P_WRITE;
                P_WRITE: begin
                    // Refusals are counted and nothing is evicted.
                    if (status_q == PLACE_TABLE_FULL) begin
                        eviction_cnt <= eviction_cnt + 32'd1;
                    end
                    state <= P_ACK;
                end
                P_ACK: begin
                    if (!ctrl_req) begin
                        state <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            P_IDLE: rule_q <= ctrl_rule;
            P_WAIT: begin
                hit_q   <= hit;
                empty_q <= empty;
            end
            // Update beats insert and the lowest way wins.
            P_DECIDE: begin
                if (|hit_q) begin
                    sel_q    <= hit_q & (~hit_q + NUM_WAYS'(1));
                    status_q <= PLACE_UPDATED;
                end else if (|empty_q) begin
                    sel_q    <= empty_q & (~empty_q + NUM_WAYS'(1));
                    status_q <= PLACE_INSERTED;
                end else begin
                    sel_q    <= '0;
                    status_q <= PLACE_TABLE_FULL;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/flow_table_top.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_table_top import ft_types_pkg::*, ft_ctrl_pkg::*; #(
    parameter int AWIDTH = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  pkt_meta_t     in_meta,
    input  logic          in_valid,
    output logic          in_ready,
    output pkt_meta_t     out_meta,
    output logic          out_valid,
    input  logic          out_ready,
    input  logic          ctrl_req,
    input  flow_rule_t    ctrl_rule,
    output logic          ctrl_ack,
    output place_status_t ctrl_status,
    output logic [31:0]   eviction_cnt
);

    logic [AWIDTH-1:0]   rd_addr [NUM_WAYS];
    logic                rd_en;
    flow_entry_t         rd_entry [NUM_WAYS];
    logic [AWIDTH-1:0]   wr_addr [NUM_WAYS];
    logic [NUM_WAYS-1:0] wr_rd;
    logic [NUM_WAYS-1:0] wr_en;
    flow_entry_t         wr_data;
    flow_entry_t         wr_entry [NUM_WAYS];

    flow_lookup #(
        .AWIDTH (AWIDTH)
    ) flow_lookup_i (
        .clk       (clk),
        .rst       (rst),
        .in_meta   (in_meta),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_meta  (out_meta),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rd_addr   (rd_addr),
        .rd_en     (rd_en),
        .rd_entry  (rd_entry)
    );

    flow_placer #(
        .AWIDTH (AWIDTH)
    ) flow_placer_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl_req     (ctrl_req),
        .ctrl_rule    (ctrl_rule),
        .ctrl_ack     (ctrl_ack),
        .ctrl_status  (ctrl_status),
        .eviction_cnt (eviction_cnt),
        .wr_addr      (wr_addr),
        .wr_rd        (wr_rd),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wr_entry     (wr_entry)
    );

    // Port A serves lookups, port B serves placement.
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        flow_subtable #(
            .AWIDTH (AWIDTH)
        ) flow_subtable_i (
            .clk     (clk),
            .rst     (rst),
            .a_addr  (rd_addr[w]),
            .a_en    (rd_en),
            .a_entry (rd_entry[w]),
            .b_addr  (wr_addr[w]),
            .b_rd    (wr_rd[w]),
            .b_wr    (wr_en[w]),
            .b_data  (wr_data),
            .b_entry (wr_entry[w])
        );
    end

endmodule

`default_nettype wire

/* dv/flow_table_props.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_table_props import ft_types_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        ctrl_req,
    input logic        ctrl_ack,
    input logic        out_ready,
    input logic        out_valid,
    input pkt_meta_t   out_meta,
    input logic [31:0] eviction_cnt
);

    ack_only_on_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ctrl_ack) |-> ctrl_req)
        else $error("ctrl_ack rose without ctrl_req");

    ack_held_until_release: assert property (@(posedge clk) disable iff (rst)
        (ctrl_ack && ctrl_req) |=> ctrl_ack)
        else $error("ctrl_ack dropped while ctrl_req was still high");

    // Output is frozen under back-pressure.
    output_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        !out_ready |=> $stable(out_valid) && (!out_valid || $stable(out_meta)))
        else $error("Lookup output changed while out_ready was low");

    counter_monotonic: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> eviction_cnt >= $past(eviction_cnt))
        else $error("eviction_cnt decreased");

endmodule

bind flow_table_top flow_table_props flow_table_props_i (
    .clk          (clk),
    .rst          (rst),
    .ctrl_req     (ctrl_req),
    .ctrl_ack     (ctrl_ack),
    .out_ready    (out_ready),
    .out_valid    (out_valid),
    .out_meta     (out_meta),
    .eviction_cnt (eviction_cnt)
);

`default_nettype wire

/* dv/flow_table_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_table_tb import ft_types_pkg::*, ft_ctrl_pkg::*;;

    localparam int AWIDTH  = 4;
    localparam int DEPTH   = 1 << AWIDTH;
    localparam int TIMEOUT = 2000;

    logic          clk;
    logic          rst;
    pkt_meta_t     in_meta;
    logic          in_valid;
    logic          in_ready;
    pkt_meta_t     out_meta;
    logic          out_valid;
    logic          out_ready;
    logic          ctrl_req;
    flow_rule_t    ctrl_rule;
    logic          ctrl_ack;
    place_status_t ctrl_status;
    logic [31:0]   eviction_cnt;

    int seed = 13;

    // Reference copy of every way.
    logic      m_valid [NUM_WAYS][DEPTH];
    tuple_t    m_tuple [NUM_WAYS][DEPTH];
    queue_id_t m_queue [NUM_WAYS][DEPTH];
    int        evictions;

    pkt_meta_t exp_q [$];
    tuple_t    known [$];

    flow_table_top #(
        .AWIDTH (AWIDTH)
    ) flow_table_top_i (
        .clk          (clk),
        .rst          (rst),
        .in_meta      (in_meta),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_meta     (out_meta),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .ctrl_req     (ctrl_req),
        .ctrl_rule    (ctrl_rule),
        .ctrl_ack     (ctrl_ack),
        .ctrl_status  (ctrl_status),
        .eviction_cnt (eviction_cnt)
    );

    always #50 clk = ~clk;

    task automatic fail_value(input string name, input tuple_t got, input tuple_t expected);
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic fail_plain(input string reason);
        $display("%s at time %0t", reason, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    // Fold in AWIDTH-bit chunks, then step by the way offset.
    function automatic int slot_of(tuple_t t, int way);
        logic [AWIDTH-1:0] acc;
        tuple_t            rest;
        acc  = '0;
        rest = t;
        for (int c = 0; c < (96 + AWIDTH - 1) / AWIDTH; c++) begin
            acc  = acc ^ rest[AWIDTH-1:0];
            rest = rest >> AWIDTH;
        end
        return (int'(acc) + way * HASH_STRIDE) % DEPTH;
    endfunction

    function automatic void model_clear();
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int s = 0; s < DEPTH; s++) begin
                m_valid[w][s] = 1'b0;
            end
        end
        evictions = 0;
    endfunction

    function automatic queue_id_t model_lookup(tuple_t t);
        int s;
        for (int w = 0; w < NUM_WAYS; w++) begin
            s = slot_of(t, w);
            if (m_valid[w][s] && m_tuple[w][s] == t) begin
                return m_queue[w][s];
            end
        end
        return DROP_QUEUE;
    endfunction

    // Update first, then the lowest empty way, else refuse.
    function automatic place_status_t model_place(tuple_t t, queue_id_t q);
        int s;
        for (int w = 0; w < NUM_WAYS; w++) begin
            s = slot_of(t, w);
            if (m_valid[w][s] && m_tuple[w][s] == t) begin
                m_queue[w][s] = q;
                return PLACE_UPDATED;
            end
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            s = slot_of(t, w);
            if (!m_valid[w][s]) begin
                m_valid[w][s] = 1'b1;
                m_tuple[w][s] = t;
                m_queue[w][s] = q;
                return PLACE_INSERTED;
            end
        end
        evictions++;
        return PLACE_TABLE_FULL;
    endfunction

    function automatic tuple_t random_tuple();
        return {$random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic queue_id_t random_queue();
        return queue_id_t'($random(seed)) & 8'h7f;
    endfunction

    always @(posedge clk) begin
        pkt_meta_t e;
        if (!rst && out_valid && out_ready) begin
            assert (exp_q.size() != 0)
            else fail_plain("Lookup result arrived with no packet outstanding");
            e = exp_q.pop_front();
            assert (out_meta.tuple == e.tuple)
            else fail_value("out_meta.tuple", out_meta.tuple, e.tuple);
            assert (out_meta.pkt_len == e.pkt_len)
            else fail_value("out_meta.pkt_len", tuple_t'(out_meta.pkt_len), tuple_t'(e.pkt_len));
            assert (out_meta.queue_id == e.queue_id)
            else fail_value("out_meta.queue_id", tuple_t'(out_meta.queue_id),
                            tuple_t'(e.queue_id));
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        ctrl_req  <= 1'b0;
        out_ready <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        model_clear();
        known.delete();
    endtask

    // Holds each packet until accepted. Throttle adds gaps and stalls.
    task automatic send_packets(input tuple_t list [$], input bit throttle);
        int        idx;
        int        stalls;
        pkt_meta_t m;
        pkt_meta_t e;
        idx    = 0;
        stalls = 0;
        while (idx < list.size()) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                e          = in_meta;
                e.queue_id = model_lookup(in_meta.tuple);
                exp_q.push_back(e);
                idx++;
                stalls = 0;
            end else begin
                stalls++;
                assert (stalls < TIMEOUT) else fail_plain("Timeout waiting for in_ready");
            end
            if (!in_valid || in_ready) begin
                if (idx < list.size() && (!throttle || ($random(seed) % 3) != 0)) begin
                    m.tuple    = list[idx];
                    m.queue_id = queue_id_t'($random(seed));
                    m.pkt_len  = pkt_len_t'($random(seed));
                    in_meta  <= m;
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= throttle ? (($random(seed) % 4) != 0) : 1'b1;
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        out_ready <= 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else fail_plain("Timeout waiting for lookup results");
        end
    endtask

    task automatic apply_rule(input tuple_t t, input queue_id_t q, output place_status_t got);
        place_status_t want;
        int            cycles;
        want = model_place(t, q);
        @(posedge clk);
        ctrl_rule <= '{tuple: t, queue_id: q};
        ctrl_req  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else fail_plain("Timeout waiting for ctrl_ack to rise");
        end while (!ctrl_ack);
        got = ctrl_status;
        assert (ctrl_status == want)
        else fail_value("ctrl_status", tuple_t'(ctrl_status), tuple_t'(want));
        assert (eviction_cnt == 32'(evictions))
        else fail_value("eviction_cnt", tuple_t'(eviction_cnt), tuple_t'(evictions));
        ctrl_req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else fail_plain("Timeout waiting for ctrl_ack to fall");
        end while (ctrl_ack);
    endtask

    initial begin
        tuple_t        list [$];
        tuple_t        base;
        place_status_t st;
        queue_id_t     q;
        clk       = 1'b0;
        rst       = 1'b1;
        in_meta   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        ctrl_req  = 1'b0;
        ctrl_rule = '0;
        model_clear();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Empty table after reset.
        @(posedge clk);
        assert (out_valid == 1'b0) else fail_value("out_valid", tuple_t'(out_valid), '0);
        assert (ctrl_ack == 1'b0) else fail_value("ctrl_ack", tuple_t'(ctrl_ack), '0);
        assert (eviction_cnt == 32'd0)
        else fail_value("eviction_cnt", tuple_t'(eviction_cnt), '0);
        for (int i = 0; i < 8; i++) begin
            list.push_back(random_tuple());
        end
        send_packets(list, 1'b0);
        drain();

        // New flows.
        for (int i = 0; i < 6; i++) begin
            base = random_tuple();
            apply_rule(base, random_queue(), st);
            assert (st == PLACE_INSERTED)
            else fail_value("ctrl_status", tuple_t'(st), tuple_t'(PLACE_INSERTED));
            known.push_back(base);
        end
        send_packets(known, 1'b0);
        drain();

        // Existing flow gets a new queue.
        q = model_lookup(known[0]) ^ 8'h01;
        apply_rule(known[0], q, st);
        assert (st == PLACE_UPDATED)
        else fail_value("ctrl_status", tuple_t'(st), tuple_t'(PLACE_UPDATED));
        list.delete();
        list.push_back(known[0]);
        send_packets(list, 1'b0);
        drain();

        // Five tuples with one fold fill all four ways.
        apply_reset();
        base = random_tuple();
        list.delete();
        for (int k = 0; k < 5; k++) begin
            list.push_back(base ^ tuple_t'(k) ^ (tuple_t'(k) << AWIDTH));
        end
        for (int k = 0; k < 5; k++) begin
            apply_rule(list[k], random_queue(), st);
            if (k < 4) begin
                assert (st == PLACE_INSERTED)
                else fail_value("ctrl_status", tuple_t'(st), tuple_t'(PLACE_INSERTED));
                known.push_back(list[k]);
            end else begin
                assert (st == PLACE_TABLE_FULL)
                else fail_value("ctrl_status", tuple_t'(st), tuple_t'(PLACE_TABLE_FULL));
            end
        end
        assert (eviction_cnt == 32'd1)
        else fail_value("eviction_cnt", tuple_t'(eviction_cnt), tuple_t'(1));
        assert (model_lookup(list[4]) == DROP_QUEUE)
        else fail_plain("Refused tuple is present in the reference table");
        send_packets(list, 1'b0);
        drain();

        // Mixed stream under back-pressure.
        for (int i = 0; i < 8; i++) begin
            base = random_tuple();
            apply_rule(base, random_queue(), st);
            known.push_back(base);
        end
        list.delete();
        for (int i = 0; i < 60; i++) begin
            if ($unsigned($random(seed)) % 5 < 3) begin
                list.push_back(known[$unsigned($random(seed)) % known.size()]);
            end else begin
                list.push_back(random_tuple());
            end
        end
        send_packets(list, 1'b1);
        drain();

        repeat (4) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/ft_types_pkg.sv
verilog/ft_ctrl_pkg.sv
verilog/flow_subtable.sv
verilog/flow_lookup.sv
verilog/flow_placer.sv
verilog/flow_table_top.sv
dv/flow_table_props.sv
dv/flow_table_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the flow table testbench with Verilator and run it.
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -j 0 \
        --top-module flow_table_tb -f vlog.f -o flow_table_sim &&
    ./obj_dir/flow_table_sim ||
    exit 1
